/* include/rv_core_defines.svh */
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// Datapath and address widths
`define RV_XLEN        32
`define RV_PC_WIDTH    10

// Memory sizes in 32-bit words
`define RV_IMEM_DEPTH  256
`define RV_DMEM_DEPTH  64

// addi x0, x0, 0
`define RV_NOP         32'h0000_0013

// jal x0, 0 spins on itself, taken as end of program
`define RV_HALT_INSN   32'h0000_006f

`endif

/* hdl/rv_pkg.sv */
package rv_pkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        // LUI result is the immediate itself
        PASS_B = 4'd10
    } alu_op_e;

    // Same encoding as funct3 of loads and stores
    typedef enum logic [2:0] {
        BYTE   = 3'b000,
        HALF   = 3'b001,
        WORD   = 3'b010,
        BYTE_U = 3'b100,
        HALF_U = 3'b101
    } mem_size_e;

endpackage

/* hdl/rv_pipe_if.sv */
`timescale 1ns/100ps
`include "rv_core_defines.svh"

// Decode to execute
interface id_ex_if
    import rv_pkg::*;
();
    logic [`RV_PC_WIDTH-1:0] pc;
    logic [`RV_XLEN-1:0]     rs1_data;
    logic [`RV_XLEN-1:0]     rs2_data;
    logic [`RV_XLEN-1:0]     imm;
    logic [4:0]              rs1;
    logic [4:0]              rs2;
    logic [4:0]              rd;
    alu_op_e                 alu_op;
    logic                    alu_src;
    logic                    auipc;
    logic                    mem_write;
    logic                    mem2reg;
    logic                    reg_write;
    mem_size_e               mem_size;
    logic                    halt;

    modport producer (output pc, rs1_data, rs2_data, imm, rs1, rs2, rd, alu_op,
                      alu_src, auipc, mem_write, mem2reg, reg_write, mem_size, halt);
    modport consumer (input pc, rs1_data, rs2_data, imm, rs1, rs2, rd, alu_op,
                      alu_src, auipc, mem_write, mem2reg, reg_write, mem_size, halt);
endinterface

// Execute to memory
interface ex_mem_if
    import rv_pkg::*;
();
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] store_data;
    logic [4:0]          rd;
    logic                mem_write;
    logic                mem2reg;
    logic                reg_write;
    mem_size_e           mem_size;
    logic                halt;

    modport producer (output alu_result, store_data, rd, mem_write, mem2reg, reg_write,
                      mem_size, halt);
    modport consumer (input alu_result, store_data, rd, mem_write, mem2reg, reg_write,
                      mem_size, halt);
endinterface

// Memory to writeback, read by decode and execute
interface mem_wb_if;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] mem_data;
    logic [4:0]          rd;
    logic                mem2reg;
    logic                reg_write;
    logic                halt;

    modport producer (output alu_result, mem_data, rd, mem2reg, reg_write, halt);
    modport consumer (input alu_result, mem_data, rd, mem2reg, reg_write, halt);
endinterface

/* hdl/rv_fetch.sv */
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_fetch (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_stall,
    input  logic                    i_imem_we,
    input  logic [`RV_PC_WIDTH-3:0] i_imem_addr,
    input  logic [`RV_XLEN-1:0]     i_imem_wdata,
    output logic [`RV_PC_WIDTH-1:0] o_pc,
    output logic [`RV_XLEN-1:0]     o_instr,
    output logic                    o_halt_seen
);

    logic [`RV_XLEN-1:0]     imem [`RV_IMEM_DEPTH];
    logic [`RV_PC_WIDTH-1:0] pc;
    logic                    halt_hit;
    logic [`RV_XLEN-1:0]     fetch_word;

    assign halt_hit = (o_instr == `RV_HALT_INSN);
    // Nothing past the halt reaches decode
    assign fetch_word = (o_halt_seen || halt_hit) ? `RV_NOP : imem[pc[`RV_PC_WIDTH-1:2]];

    // Program load port, only open while the core sits in reset
    always_ff @(posedge clk)
    begin
        if (i_rst && i_imem_we)
            imem[i_imem_addr] <= i_imem_wdata;
    end

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            pc          <= '0;
            o_pc        <= '0;
            o_instr     <= `RV_NOP;
            o_halt_seen <= 1'b0;
        end
        else
        begin
            if (halt_hit)
                o_halt_seen <= 1'b1;
            if (!i_stall)
            begin
                o_pc    <= pc;
                o_instr <= fetch_word;
                if (!o_halt_seen && !halt_hit)
                    pc <= pc + `RV_PC_WIDTH'(4);
            end
        end
    end

    a_pc_frozen: assert property (@(posedge clk) disable iff (i_rst)
        o_halt_seen |=> $stable(pc));

endmodule

/* hdl/rv_decode.sv */
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_decode
    import rv_pkg::*;
(
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic [`RV_PC_WIDTH-1:0] i_pc,
    input  logic [`RV_XLEN-1:0]     i_instr,
    input  logic                    i_halt_seen,
    input  logic [4:0]              i_dbg_addr,
    output logic                    o_stall,
    output logic [`RV_XLEN-1:0]     o_dbg_data,
    id_ex_if.producer               id_ex,
    mem_wb_if.consumer              mem_wb
);

    opcode_e             opcode;
    alu_op_e             alu_op;
    logic [2:0]          funct3;
    logic [4:0]          rs1, rs2, rd;
    logic [`RV_XLEN-1:0] imm_i, imm_s, imm_u, imm;
    logic                alu_src, auipc, mem_write, mem2reg, reg_write;
    logic                uses_rs1, uses_rs2;
    logic [`RV_XLEN-1:0] wb_data;
    logic [`RV_XLEN-1:0] regs [1:31];

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    // Register read sees a same-cycle writeback
    function automatic logic [`RV_XLEN-1:0] rf_read(input logic [4:0] idx);
        if (idx == 5'd0)
            return '0;
        if (mem_wb.reg_write && mem_wb.rd == idx)
            return wb_data;
        return regs[idx];
    endfunction

    assign opcode = opcode_e'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    assign rs1    = i_instr[19:15];
    assign rs2    = i_instr[24:20];
    assign rd     = i_instr[11:7];
    assign imm_i  = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s  = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_u  = {i_instr[31:12], 12'b0};

    always_comb
    begin
        alu_op    = ADD;
        imm       = imm_i;
        alu_src   = 1'b0;
        auipc     = 1'b0;
        mem_write = 1'b0;
        mem2reg   = 1'b0;
        reg_write = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        case (opcode)
            OP:
            begin
                alu_op    = alu_decode(funct3, i_instr[30]);
                reg_write = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            OP_IMM:
            begin
                // bit 30 is part of the immediate except for shifts
                alu_op    = alu_decode(funct3, i_instr[30] && funct3 == 3'b101);
                alu_src   = 1'b1;
                reg_write = 1'b1;
                uses_rs1  = 1'b1;
            end
            LOAD:
            begin
                alu_src   = 1'b1;
                mem2reg   = 1'b1;
                reg_write = 1'b1;
                uses_rs1  = 1'b1;
            end
            STORE:
            begin
                imm       = imm_s;
                alu_src   = 1'b1;
                mem_write = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            LUI:
            begin
                alu_op    = PASS_B;
                imm       = imm_u;
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            AUIPC:
            begin
                imm       = imm_u;
                alu_src   = 1'b1;
                auipc     = 1'b1;
                reg_write = 1'b1;
            end
            default:
            begin
                // JAL (halt) and unknown words retire as no-ops
                alu_op = ADD;
            end
        endcase
    end

    assign wb_data    = mem_wb.mem2reg ? mem_wb.mem_data : mem_wb.alu_result;
    assign o_dbg_data = rf_read(i_dbg_addr);

    // Load in ID/EX feeding this instruction
    assign o_stall = id_ex.mem2reg && id_ex.reg_write &&
                     ((uses_rs1 && rs1 == id_ex.rd) || (uses_rs2 && rs2 == id_ex.rd));

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (mem_wb.reg_write)
            regs[mem_wb.rd] <= wb_data;
    end

    // ID/EX control, bubble on reset or load-use stall
    always_ff @(posedge clk)
    begin
        if (i_rst || o_stall)
        begin
            id_ex.rd        <= '0;
            id_ex.mem_write <= 1'b0;
            id_ex.mem2reg   <= 1'b0;
            id_ex.reg_write <= 1'b0;
            id_ex.halt      <= 1'b0;
        end
        else
        begin
            id_ex.rd        <= rd;
            id_ex.mem_write <= mem_write;
            id_ex.mem2reg   <= mem2reg;
            id_ex.reg_write <= reg_write && (rd != 5'd0);
            id_ex.halt      <= i_halt_seen;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk)
    begin
        id_ex.pc       <= i_pc;
        id_ex.rs1_data <= rf_read(rs1);
        id_ex.rs2_data <= rf_read(rs2);
        id_ex.imm      <= imm;
        id_ex.rs1      <= rs1;
        id_ex.rs2      <= rs2;
        id_ex.alu_op   <= alu_op;
        id_ex.alu_src  <= alu_src;
        id_ex.auipc    <= auipc;
        id_ex.mem_size <= mem_size_e'(funct3);
    end

    // x0 loses its write enable here, three stages before writeback
    a_no_x0_write: assert property (@(posedge clk) disable iff (i_rst)
        mem_wb.reg_write |-> mem_wb.rd != 5'd0);

endmodule

/* hdl/rv_execute.sv */
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_execute
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst,
    id_ex_if.consumer  id_ex,
    ex_mem_if.producer ex_mem,
    mem_wb_if.consumer mem_wb
);

    logic [`RV_XLEN-1:0] wb_data;
    logic [`RV_XLEN-1:0] rs1_fwd;
    logic [`RV_XLEN-1:0] rs2_fwd;
    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;

    // Youngest producer wins
    function automatic logic [`RV_XLEN-1:0] fwd_operand(input logic [4:0] rs,
                                                        input logic [`RV_XLEN-1:0] reg_val);
        if (ex_mem.reg_write && ex_mem.rd != 5'd0 && ex_mem.rd == rs)
            return ex_mem.alu_result;
        if (mem_wb.reg_write && mem_wb.rd != 5'd0 && mem_wb.rd == rs)
            return wb_data;
        return reg_val;
    endfunction

    assign wb_data = mem_wb.mem2reg ? mem_wb.mem_data : mem_wb.alu_result;
    assign rs1_fwd = fwd_operand(id_ex.rs1, id_ex.rs1_data);
    assign rs2_fwd = fwd_operand(id_ex.rs2, id_ex.rs2_data);

    assign alu_a = id_ex.auipc ? {{(`RV_XLEN-`RV_PC_WIDTH){1'b0}}, id_ex.pc} : rs1_fwd;
    assign alu_b = id_ex.alu_src ? id_ex.imm : rs2_fwd;

    always_comb
    begin
        case (id_ex.alu_op)
            SUB:     alu_result = alu_a - alu_b;
            SLL:     alu_result = alu_a << alu_b[4:0];
            SLT:     alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            SLTU:    alu_result = {{(`RV_XLEN-1){1'b0}}, alu_a < alu_b};
            XOR:     alu_result = alu_a ^ alu_b;
            SRL:     alu_result = alu_a >> alu_b[4:0];
            SRA:     alu_result = $signed(alu_a) >>> alu_b[4:0];
            OR:      alu_result = alu_a | alu_b;
            AND:     alu_result = alu_a & alu_b;
            PASS_B:  alu_result = alu_b;
            default: alu_result = alu_a + alu_b;
        endcase
    end

    // EX/MEM control
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            ex_mem.rd        <= '0;
            ex_mem.mem_write <= 1'b0;
            ex_mem.mem2reg   <= 1'b0;
            ex_mem.reg_write <= 1'b0;
            ex_mem.halt      <= 1'b0;
        end
        else
        begin
            ex_mem.rd        <= id_ex.rd;
            ex_mem.mem_write <= id_ex.mem_write;
            ex_mem.mem2reg   <= id_ex.mem2reg;
            ex_mem.reg_write <= id_ex.reg_write;
            ex_mem.halt      <= id_ex.halt;
        end
    end

    always_ff @(posedge clk)
    begin
        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= rs2_fwd;
        ex_mem.mem_size   <= id_ex.mem_size;
    end

endmodule

/* hdl/rv_memory.sv */
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_memory
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst,
    ex_mem_if.consumer ex_mem,
    mem_wb_if.producer mem_wb,
    output logic       o_halted
);

    localparam int dmem_aw = $clog2(`RV_DMEM_DEPTH);

    logic [3:0][7:0]     dmem [`RV_DMEM_DEPTH];
    logic [dmem_aw-1:0]  word_idx;
    logic [1:0]          byte_off;
    logic [3:0]          byte_en;
    logic [`RV_XLEN-1:0] lane_data;
    logic [`RV_XLEN-1:0] shifted;
    logic [`RV_XLEN-1:0] load_data;

    assign word_idx = ex_mem.alu_result[dmem_aw+1:2];
    assign byte_off = ex_mem.alu_result[1:0];

    // Replicate store data on every lane, enables pick the right ones
    always_comb
    begin
        case (ex_mem.mem_size)
            BYTE, BYTE_U:
            begin
                byte_en   = 4'b0001 << byte_off;
                lane_data = {4{ex_mem.store_data[7:0]}};
            end
            HALF, HALF_U:
            begin
                byte_en   = 4'b0011 << byte_off;
                lane_data = {2{ex_mem.store_data[15:0]}};
            end
            default:
            begin
                byte_en   = 4'b1111;
                lane_data = ex_mem.store_data;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (ex_mem.mem_write)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (byte_en[i])
                    dmem[word_idx][i] <= lane_data[8*i +: 8];
            end
        end
    end

    assign shifted = dmem[word_idx] >> {byte_off, 3'b000};

    always_comb
    begin
        case (ex_mem.mem_size)
            BYTE:    load_data = {{24{shifted[7]}}, shifted[7:0]};
            HALF:    load_data = {{16{shifted[15]}}, shifted[15:0]};
            BYTE_U:  load_data = {24'b0, shifted[7:0]};
            HALF_U:  load_data = {16'b0, shifted[15:0]};
            default: load_data = shifted;
        endcase
    end

    // MEM/WB control, halt is sticky until reset
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            mem_wb.rd        <= '0;
            mem_wb.mem2reg   <= 1'b0;
            mem_wb.reg_write <= 1'b0;
            mem_wb.halt      <= 1'b0;
        end
        else
        begin
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.mem2reg   <= ex_mem.mem2reg;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.halt      <= mem_wb.halt | ex_mem.halt;
        end
    end

    always_ff @(posedge clk)
    begin
        mem_wb.alu_result <= ex_mem.alu_result;
        mem_wb.mem_data   <= load_data;
    end

    assign o_halted = mem_wb.halt;

    a_aligned: assert property (@(posedge clk) disable iff (i_rst)
        (ex_mem.mem_write || ex_mem.mem2reg) |->
            !((ex_mem.mem_size inside {HALF, HALF_U} && byte_off[0]) ||
              (ex_mem.mem_size == WORD && byte_off != 2'b00)));

endmodule

/* hdl/rv_core_top.sv */
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_core_top (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_imem_we,
    input  logic [`RV_PC_WIDTH-3:0] i_imem_addr,
    input  logic [`RV_XLEN-1:0]     i_imem_wdata,
    input  logic [4:0]              i_dbg_addr,
    output logic                    o_halted,
    output logic [`RV_XLEN-1:0]     o_dbg_data
);

    logic [`RV_PC_WIDTH-1:0] if_pc;
    logic [`RV_XLEN-1:0]     if_instr;
    logic                    halt_seen;
    logic                    stall;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();
    mem_wb_if mem_wb ();

    rv_fetch u_fetch (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_stall      (stall),
        .i_imem_we    (i_imem_we),
        .i_imem_addr  (i_imem_addr),
        .i_imem_wdata (i_imem_wdata),
        .o_pc         (if_pc),
        .o_instr      (if_instr),
        .o_halt_seen  (halt_seen)
    );

    // Register file and writeback live here
    rv_decode u_decode (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_pc        (if_pc),
        .i_instr     (if_instr),
        .i_halt_seen (halt_seen),
        .i_dbg_addr  (i_dbg_addr),
        .o_stall     (stall),
        .o_dbg_data  (o_dbg_data),
        .id_ex       (id_ex.producer),
        .mem_wb      (mem_wb.consumer)
    );

    rv_execute u_execute (
        .clk    (clk),
        .i_rst  (i_rst),
        .id_ex  (id_ex.consumer),
        .ex_mem (ex_mem.producer),
        .mem_wb (mem_wb.consumer)
    );

    rv_memory u_memory (
        .clk      (clk),
        .i_rst    (i_rst),
        .ex_mem   (ex_mem.consumer),
        .mem_wb   (mem_wb.producer),
        .o_halted (o_halted)
    );

endmodule

/* bench/rv_tb_pkg.sv */
`include "rv_core_defines.svh"

package rv_tb_pkg;

    localparam int cls_rr    = 1;
    localparam int cls_imm   = 2;
    localparam int cls_upper = 4;
    localparam int cls_mem   = 8;
    localparam int body_len  = 40;
    // Base setup, window clear, body, halt and two words that must never run
    localparam int prog_words = 2 + 16 + body_len + 1 + 2;

    localparam logic [6:0] opc_op    = 7'b0110011;
    localparam logic [6:0] opc_imm   = 7'b0010011;
    localparam logic [6:0] opc_load  = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_lui   = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // x31 holds the data window base and is never a destination
    function automatic void gen_program(input int classes, input bit dense,
                                        output logic [31:0] prog [$]);
        logic [31:0] r;
        logic [4:0]  rd, rs1, rs2, last1, last2;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          cls;
        int          idx;
        bit          is_store;
        prog  = {};
        last1 = 5'd0;
        last2 = 5'd0;
        r = $urandom;
        prog.push_back(enc_u(r[19:0], 5'd31, opc_lui));
        prog.push_back(enc_i({r[25:20], 6'b0}, 5'd31, 3'b000, 5'd31, opc_imm));
        for (int k = 0; k < 16; k++)
            prog.push_back(enc_s(12'(4 * k), 5'd0, 5'd31, 3'b010));
        for (int i = 0; i < body_len; i++)
        begin
            r        = $urandom;
            rd       = 5'($urandom_range(1, 30));
            is_store = 1'b0;
            // Dense mode reads the last two destinations
            rs1 = dense ? (r[31] ? last1 : last2) : r[4:0];
            rs2 = dense ? (r[31] ? last2 : last1) : r[9:5];
            // First eight are seeds so the registers hold something
            cls = 0;
            while (i >= 8 && (cls & classes) == 0)
                cls = 1 << $urandom_range(0, 3);
            f3 = r[12:10];
            case (cls)
                cls_rr:
                    prog.push_back(enc_r((r[13] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                                         rs2, rs1, f3, rd));
                cls_imm:
                begin
                    imm = r[25:14];
                    if (f3 == 3'd1)
                        imm = {7'h00, r[18:14]};
                    if (f3 == 3'd5)
                        imm = {r[13] ? 7'h20 : 7'h00, r[18:14]};
                    prog.push_back(enc_i(imm, rs1, f3, rd, opc_imm));
                end
                cls_upper:
                    prog.push_back(enc_u(r[29:10], rd, r[30] ? opc_auipc : opc_lui));
                cls_mem:
                begin
                    is_store = r[13];
                    idx = is_store ? $urandom_range(0, 2) : $urandom_range(0, 4);
                    f3  = (idx > 2) ? 3'(idx + 1) : 3'(idx);
                    imm = 12'($urandom_range(0, 63) & ~((1 << f3[1:0]) - 1));
                    if (is_store)
                        prog.push_back(enc_s(imm, rs2, 5'd31, f3));
                    else
                        prog.push_back(enc_i(imm, 5'd31, f3, rd, opc_load));
                end
                default:
                    prog.push_back(r[13] ? enc_u(r[31:12], rd, opc_lui)
                                         : enc_i(r[31:20], 5'd0, 3'b000, rd, opc_imm));
            endcase
            if (!is_store)
            begin
                last2 = last1;
                last1 = rd;
            end
        end
        prog.push_back(`RV_HALT_INSN);
        r = $urandom;
        prog.push_back(enc_i(r[31:20], 5'd0, 3'b000, 5'(1 + r[3:0]), opc_imm));
        prog.push_back(enc_u(r[23:4], 5'(17 + r[7:4]), opc_lui));
    endfunction

    // RV32I integer semantics, alt is instruction bit 30
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input bit alt,
                                            input logic [31:0] a, b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5:
            begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Sequential execution up to the halt word
    function automatic void run_model(input logic [31:0] prog [$],
                                      output logic [31:0] regs [32]);
        logic [7:0]  mem [256];
        logic [31:0] insn, a, b, res, addr, word, imm_i, imm_s, imm_u;
        logic [4:0]  rd;
        logic [2:0]  f3;
        int          idx;
        for (int k = 0; k < 32; k++)
            regs[k] = '0;
        for (int k = 0; k < 256; k++)
            mem[k] = '0;
        idx = 0;
        while (idx < prog.size() && prog[idx] != `RV_HALT_INSN)
        begin
            insn  = prog[idx];
            rd    = insn[11:7];
            f3    = insn[14:12];
            a     = regs[insn[19:15]];
            b     = regs[insn[24:20]];
            imm_i = {{20{insn[31]}}, insn[31:20]};
            imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
            imm_u = {insn[31:12], 12'b0};
            res   = regs[rd];
            case (insn[6:0])
                opc_op:    res = alu_ref(f3, insn[30], a, b);
                opc_imm:   res = alu_ref(f3, insn[30] && f3 == 3'd5, a, imm_i);
                opc_lui:   res = imm_u;
                opc_auipc: res = 32'(idx * 4) + imm_u;
                opc_load:
                begin
                    addr = a + imm_i;
                    for (int k = 0; k < 4; k++)
                        word[8*k +: 8] = mem[(addr[7:0] + k) % 256];
                    case (f3)
                        3'd0: res = {{24{word[7]}}, word[7:0]};
                        3'd1: res = {{16{word[15]}}, word[15:0]};
                        3'd4: res = {24'b0, word[7:0]};
                        3'd5: res = {16'b0, word[15:0]};
                        default: res = word;
                    endcase
                end
                opc_store:
                begin
                    addr = a + imm_s;
                    for (int k = 0; k < (1 << f3[1:0]); k++)
                        mem[(addr[7:0] + k) % 256] = b[8*k +: 8];
                end
                default: ;
            endcase
            if (rd != 5'd0 && insn[6:0] != opc_store)
                regs[rd] = res;
            idx++;
        end
    endfunction

endpackage

/* bench/rv_core_tb.sv */
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_core_tb
    import rv_tb_pkg::*;
();

    localparam int clk_period  = 20;
    localparam int rst_cycles  = 16;
    localparam int n_tests     = 5;
    localparam int halt_limit  = prog_words * 2 + 40;
    // Load, reset, run to halt, drain and register readout
    localparam int test_cycles = prog_words + rst_cycles + halt_limit + 8 + 32 + 4;

    logic                      clk;
    logic                      rst;
    logic                      imem_we;
    logic [`RV_PC_WIDTH-3:0]   imem_addr;
    logic [`RV_XLEN-1:0]       imem_wdata;
    logic [4:0]                dbg_addr;
    logic                      halted;
    logic [`RV_XLEN-1:0]       dbg_data;
    int                        pass_count = 0;
    int                        fail_count = 0;

    rv_core_top dut0 (
        .clk          (clk),
        .i_rst        (rst),
        .i_imem_we    (imem_we),
        .i_imem_addr  (imem_addr),
        .i_imem_wdata (imem_wdata),
        .i_dbg_addr   (dbg_addr),
        .o_halted     (halted),
        .o_dbg_data   (dbg_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Program goes in first, then a plain stretch of reset
    task automatic load_program(input logic [31:0] prog [$]);
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < prog.size(); i++)
        begin
            imem_we    = 1'b1;
            imem_addr  = (`RV_PC_WIDTH-2)'(i);
            imem_wdata = prog[i];
            @(negedge clk);
        end
        imem_we = 1'b0;
        repeat (rst_cycles) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic run_test(input string name, input int classes, input bit dense);
        logic [31:0] prog [$];
        logic [31:0] exp_regs [32];
        int          errs;
        int          cycles;
        errs = 0;
        gen_program(classes, dense, prog);
        run_model(prog, exp_regs);
        load_program(prog);
        assert (!halted) else
        begin
            $display("[FAIL] %s: o_halted expected 0x0, actual 0x%0h", name, halted);
            errs++;
        end
        cycles = 0;
        while (!halted && cycles < halt_limit)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (halted) else
        begin
            $display("Core never halted in test %s within %0d cycles", name, cycles);
            errs++;
        end
        // Halt must hold while the pipeline drains
        repeat (8)
        begin
            @(negedge clk);
            assert (halted) else
            begin
                $display("[FAIL] %s: o_halted expected 0x1, actual 0x%0h", name, halted);
                errs++;
            end
        end
        dbg_addr = 5'd1;
        for (int r = 1; r < 32; r++)
        begin
            @(negedge clk);
            assert (dbg_data === exp_regs[r]) else
            begin
                $display("[FAIL] %s: o_dbg_data for x%0d expected 0x%08h, actual 0x%08h",
                         name, r, exp_regs[r], dbg_data);
                errs++;
            end
            dbg_addr = 5'(r + 1);
        end
        if (errs == 0)
        begin
            pass_count++;
            $display("test %-26s ok, halted after %0d cycles", name, cycles);
        end
        else
        begin
            fail_count++;
            $display("test %-26s failed with %0d errors", name, errs);
        end
    endtask

    initial
    begin
        rst        = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        dbg_addr   = '0;
        void'($urandom(32'hd5ab6f7e));
        run_test("register-register ops", cls_rr, 1'b0);
        run_test("immediate, LUI and AUIPC", cls_imm | cls_upper, 1'b0);
        run_test("dense forwarding chains", cls_rr | cls_imm, 1'b1);
        run_test("loads and stores", cls_mem | cls_imm, 1'b1);
        run_test("mixed program and halt", cls_rr | cls_imm | cls_upper | cls_mem, 1'b0);
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        #(n_tests * test_cycles * clk_period);
        $display("Watchdog expired, the core or the testbench hung and the run was stopped");
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
hdl/rv_pkg.sv
hdl/rv_pipe_if.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_memory.sv
hdl/rv_core_top.sv
bench/rv_tb_pkg.sv
bench/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - files:
      - hdl/rv_pkg.sv
      - hdl/rv_pipe_if.sv
      - hdl/rv_fetch.sv
      - hdl/rv_decode.sv
      - hdl/rv_execute.sv
      - hdl/rv_memory.sv
      - hdl/rv_core_top.sv
  - target: test
    files:
      - bench/rv_tb_pkg.sv
      - bench/rv_core_tb.sv
